//--- hw/twin16_main_pkg.sv
// main cpu package: bus region type, interrupt levels, register widths
package twin16_main_pkg;

    // regions decoded from the 68000 address bus
    typedef enum logic [3:0] {
        rgn_rom   = 4'd0,   // program rom
        rgn_shram = 4'd1,   // ram shared with the sub cpu
        rgn_wram  = 4'd2,   // work ram
        rgn_pal   = 4'd3,   // palette, low byte only
        rgn_io    = 4'd4,   // cabinet inputs and io control
        rgn_nvram = 4'd5,
        rgn_sysrd = 4'd6,   // sysflag read, dma status
        rgn_syswr = 4'd7,   // sysflag write, video config
        rgn_fix   = 4'd8,   // fix layer
        rgn_vram  = 4'd9,   // scroll a and b
        rgn_oram  = 4'd10,  // object ram
        rgn_none  = 4'd15
    } region_t;

    // autovector levels
    localparam logic [2:0] IRQ_VBL_LEVEL = 3'd5;
    localparam logic [2:0] IRQ_SUB_LEVEL = 3'd6;   // wins over vblank

    localparam int SCROLL_W = 9;   // scroll x/y registers
    localparam int NVPAGE_W = 5;   // nvram address bits 14:10

endpackage

//--- hw/twin16_cpu_if.sv
// cpu bus interface with one modport per consumer block
`timescale 1ns/1ps

interface twin16_cpu_if;
    logic [23:1] addr;
    logic [15:0] wdata;     // cpu data out
    logic        as_n;
    logic        uds_n;
    logic        lds_n;
    logic        rnw;

    // driven from the top level pins
    modport master (output addr, wdata, as_n, uds_n, lds_n, rnw);

    modport decode (input addr, wdata, as_n, uds_n, lds_n, rnw);

    modport regs   (input addr, wdata, rnw);

    // strobes only, for wait state timing
    modport timing (input as_n, uds_n, lds_n);

    modport irq    (input addr, as_n);  // autovector acknowledge
endinterface

//--- hw/twin16_bus_map.sv
// address decoder, byte write strobes, nvram page register and read data mux
`timescale 1ns/1ps

module twin16_bus_map import twin16_main_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    twin16_cpu_if.decode bus,

    // read sources
    input  logic [15:0]  rom_data,
    input  logic [15:0]  ram_dout,
    input  logic [15:0]  sh_dout,
    input  logic [15:0]  nvram_dout,
    input  logic [15:0]  mf_dout,
    input  logic [15:0]  ma_dout,
    input  logic [15:0]  mb_dout,
    input  logic [15:0]  mo_dout,
    input  logic [ 7:0]  mp_dout,
    input  logic         dma_bsy,

    // cabinet
    input  logic [ 6:0]  joystick1,
    input  logic [ 6:0]  joystick2,
    input  logic [ 6:0]  joystick3,
    input  logic [ 2:0]  cab_1p,
    input  logic [ 2:0]  coin,
    input  logic         service,
    input  logic [19:0]  dipsw,

    output region_t      region,
    output logic         rom_cs,
    output logic         ram_cs,
    output logic [19:1]  main_addr,
    output logic [ 1:0]  ram_dsn,
    output logic [ 1:0]  pal_we,
    output logic [ 1:0]  sh_we,
    output logic [ 1:0]  nvram_we,
    output logic [ 1:0]  va_we,
    output logic [ 1:0]  vb_we,
    output logic [ 1:0]  fx_we,
    output logic [ 1:0]  oram_we,
    output logic [14:1]  nvram_addr,
    output logic [15:0]  cpu_din
);

    logic                ds_act;
    logic [ 1:0]         dws;       // byte lanes being written
    logic [NVPAGE_W-1:0] nv_page;
    logic [ 7:0]         cab_byte;

    assign ds_act = ~(bus.uds_n & bus.lds_n);

    always_comb begin
        region = rgn_none;
        if (!bus.as_n) begin
            casez (bus.addr[20:17])
                4'b000?: region = rgn_rom;
                4'b0010: region = rgn_shram;
                4'b0011: if (ds_act) region = rgn_wram;
                4'b0100: region = rgn_pal;
                4'b0101: region = bus.addr[16] ? rgn_nvram : rgn_io;
                4'b0110: region = bus.rnw ? rgn_sysrd : rgn_syswr;
                4'b1?00: region = rgn_fix;
                4'b1?01: region = rgn_vram;
                4'b1?10: region = rgn_oram;
                default: region = rgn_none;
            endcase
        end
    end

    assign rom_cs     = region == rgn_rom;
    assign ram_cs     = region == rgn_wram;
    assign main_addr  = bus.addr[19:1];
    assign ram_dsn    = {bus.uds_n, bus.lds_n};
    assign nvram_addr = {nv_page, bus.addr[9:1]};

    assign dws      = ~({2{bus.rnw}} | {bus.uds_n, bus.lds_n});
    assign pal_we   = dws & {2{region == rgn_pal}};
    assign sh_we    = dws & {2{region == rgn_shram}};
    assign nvram_we = dws & {2{region == rgn_nvram && !bus.addr[10]}};
    assign va_we    = dws & {2{region == rgn_vram && !bus.addr[13]}};
    assign vb_we    = dws & {2{region == rgn_vram &&  bus.addr[13]}};
    assign fx_we    = dws & {2{region == rgn_fix}};
    assign oram_we  = dws & {2{region == rgn_oram}};

    // a10 set turns the nvram write into a page select
    always_ff @(posedge clk) begin
        if (rst) begin
            nv_page <= '0;
        end else if (region == rgn_nvram && dws != 2'b00 && bus.addr[10]) begin
            nv_page <= bus.wdata[8 +: NVPAGE_W];
        end
    end

    always_comb begin
        cab_byte = 8'hff;
        case (bus.addr[4:3])
            2'd0: begin
                case (bus.addr[2:1])
                    2'd0: cab_byte = {1'b1, service, cab_1p, coin};
                    2'd1: cab_byte = {1'b1, joystick1};
                    2'd2: cab_byte = {1'b1, joystick2};
                    default: cab_byte = {1'b1, joystick3};
                endcase
            end
            2'd2: cab_byte = bus.addr[1] ? dipsw[7:0] : dipsw[15:8];
            2'd3: cab_byte = {4'hf, dipsw[19:16]};
            default: cab_byte = 8'hff;    // nothing mapped here
        endcase
    end

    always_ff @(posedge clk) begin
        case (region)
            rgn_rom:   cpu_din <= rom_data;
            rgn_wram:  cpu_din <= ram_dout;
            rgn_shram: cpu_din <= sh_dout;
            rgn_pal:   cpu_din <= {8'h00, mp_dout};
            rgn_io:    cpu_din <= {8'h00, cab_byte};
            rgn_nvram: cpu_din <= nvram_dout;
            rgn_sysrd: cpu_din <= {15'd0, dma_bsy};
            rgn_fix:   cpu_din <= mf_dout;
            rgn_vram:  cpu_din <= bus.addr[13] ? mb_dout : ma_dout;
            rgn_oram:  cpu_din <= mo_dout;
            default:   cpu_din <= 16'h0000;
        endcase
    end

endmodule

//--- hw/twin16_sys_regs.sv
// video configuration registers, io control bits and sound latch
`timescale 1ns/1ps

module twin16_sys_regs import twin16_main_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    twin16_cpu_if.regs          bus,
    input  region_t             region,

    output logic                hflip,
    output logic                vflip,
    output logic                vramcvf,
    output logic [2:0]          prio,
    output logic [SCROLL_W-1:0] scra_x,
    output logic [SCROLL_W-1:0] scra_y,
    output logic [SCROLL_W-1:0] scrb_x,
    output logic [SCROLL_W-1:0] scrb_y,
    output logic [15:0]         obj_dx,
    output logic [15:0]         obj_dy,
    output logic                dma_on,
    output logic                mint_en,
    output logic                sint,      // low pulls the sub cpu interrupt
    output logic                sndon,
    output logic [7:0]          snd_latch
);

    logic io_wr;

    assign io_wr = region == rgn_io && !bus.rnw;

    always_ff @(posedge clk) begin
        if (rst) begin
            hflip   <= 1'b0;
            vflip   <= 1'b0;
            vramcvf <= 1'b0;
            prio    <= '0;
            scra_x  <= '0;
            scra_y  <= '0;
            scrb_x  <= '0;
            scrb_y  <= '0;
            obj_dx  <= '0;
            obj_dy  <= '0;
            dma_on  <= 1'b0;
            mint_en <= 1'b0;
            sint    <= 1'b1;
            sndon   <= 1'b0;
        end else begin
            if (region == rgn_syswr) begin
                case (bus.addr[3:1])
                    3'd0: {vramcvf, prio, hflip, vflip} <= bus.wdata[5:0];
                    3'd1: obj_dx <= bus.wdata;
                    3'd2: obj_dy <= bus.wdata;
                    3'd3: scra_x <= bus.wdata[SCROLL_W-1:0];
                    3'd4: scra_y <= bus.wdata[SCROLL_W-1:0];
                    3'd5: scrb_x <= bus.wdata[SCROLL_W-1:0];
                    3'd6: scrb_y <= bus.wdata[SCROLL_W-1:0];
                    default: ;   // offset 7 unused
                endcase
            end
            // offset 2 is the watchdog, not modeled
            if (io_wr && bus.addr[4:3] == 2'd0) begin
                {dma_on, mint_en, sint, sndon} <= bus.wdata[6:3];
            end
        end
    end

    // command byte for the sound cpu
    always_ff @(posedge clk) begin
        if (io_wr && bus.addr[4:3] == 2'd1) begin
            snd_latch <= bus.wdata[7:0];
        end
    end

endmodule

//--- hw/twin16_dtack_gen.sv
// fractional cpu clock enable and dtack generation with wait states
`timescale 1ns/1ps

module twin16_dtack_gen import twin16_main_pkg::*; #(
    parameter int CEN_NUM = 3,
    parameter int CEN_DEN = 16
) (
    input  logic         clk,
    input  logic         rst,
    twin16_cpu_if.timing bus,
    input  region_t      region,
    input  logic         rom_ok,
    input  logic         ram_ok,
    input  logic         dma_bsy,

    output logic         cpu_cen,
    output logic         cpu_cenb,
    output logic         dtack_n
);

    localparam int AW = $clog2(CEN_DEN + CEN_NUM) + 1;
    localparam logic [AW-1:0] NUM  = AW'(CEN_NUM);
    localparam logic [AW-1:0] DEN  = AW'(CEN_DEN);
    localparam logic [AW-1:0] HALF = AW'(CEN_DEN / 2);

    logic [AW-1:0] acc;
    logic [AW-1:0] sum;
    logic [1:0]    low_cnt;   // clocks with as_n low, saturates at 2
    logic          ds_act;
    logic          busy;

    assign sum = acc + NUM;

    // cen on wrap, cenb when crossing the half point
    always_ff @(posedge clk) begin
        if (rst) begin
            acc      <= '0;
            cpu_cen  <= 1'b0;
            cpu_cenb <= 1'b0;
        end else begin
            cpu_cen  <= sum >= DEN;
            cpu_cenb <= acc < HALF && sum >= HALF;
            acc      <= sum >= DEN ? sum - DEN : sum;
        end
    end

    assign ds_act = ~(bus.uds_n & bus.lds_n);

    // slow memories stretch the cycle
    assign busy = (region == rgn_rom  && !rom_ok) ||
                  (region == rgn_wram && !ram_ok) ||
                  (region == rgn_oram && dma_bsy);

    always_ff @(posedge clk) begin
        if (rst) begin
            low_cnt <= '0;
            dtack_n <= 1'b1;
        end else begin
            if (bus.as_n) begin
                low_cnt <= '0;
            end else if (low_cnt != 2'd2) begin
                low_cnt <= low_cnt + 2'd1;
            end

            if (bus.as_n) begin
                dtack_n <= 1'b1;
            end else if (cpu_cen && low_cnt == 2'd2 && ds_act && !busy) begin
                dtack_n <= 1'b0;   // held until as_n goes back up
            end
        end
    end

endmodule

//--- hw/twin16_ints.sv
// vblank and sub cpu interrupt requests, ipl encoding and autovector ack
`timescale 1ns/1ps

module twin16_ints import twin16_main_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        lvbl,
    input  logic        mint,      // active low request from sub cpu
    input  logic        mint_en,
    twin16_cpu_if.irq   bus,

    output logic [2:0]  ipl_n,
    output logic        vpa_n
);

    logic lvbl_l;
    logic vbl_req;
    logic sub_req;
    logic iack;

    // interrupt acknowledge shows up as a high a23
    assign iack = !bus.as_n && bus.addr[23];

    always_ff @(posedge clk) begin
        if (rst) begin
            lvbl_l  <= lvbl;
            vbl_req <= 1'b0;
            sub_req <= 1'b0;
            ipl_n   <= 3'b111;
            vpa_n   <= 1'b1;
        end else begin
            lvbl_l <= lvbl;
            if (lvbl_l && !lvbl) vbl_req <= 1'b1;   // start of blank
            if (!mint && mint_en) sub_req <= 1'b1;

            if (iack && bus.addr[3:1] == IRQ_VBL_LEVEL) vbl_req <= 1'b0;
            if (iack && bus.addr[3:1] == IRQ_SUB_LEVEL) sub_req <= 1'b0;
            if (!mint_en) sub_req <= 1'b0;

            vpa_n <= !iack;

            if (sub_req) begin
                ipl_n <= ~IRQ_SUB_LEVEL;
            end else if (vbl_req) begin
                ipl_n <= ~IRQ_VBL_LEVEL;
            end else begin
                ipl_n <= 3'b111;
            end
        end
    end

endmodule

//--- hw/twin16_main.sv
// main cpu glue top level: bus pins, decoder, registers, dtack and interrupts
`timescale 1ns/1ps

module twin16_main import twin16_main_pkg::*; #(
    parameter int CEN_NUM = 3,
    parameter int CEN_DEN = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                lvbl,

    // 68000 bus
    input  logic [23:1]         addr,
    input  logic [15:0]         cpu_dout,
    input  logic                as_n,
    input  logic                uds_n,
    input  logic                lds_n,
    input  logic                rnw,
    output logic [15:0]         cpu_din,
    output logic                dtack_n,
    output logic                vpa_n,
    output logic [2:0]          ipl_n,
    output logic                cpu_cen,
    output logic                cpu_cenb,

    // memories
    input  logic [15:0]         rom_data,
    input  logic                rom_ok,
    input  logic [15:0]         ram_dout,
    input  logic                ram_ok,
    input  logic [15:0]         sh_dout,
    input  logic [15:0]         nvram_dout,
    input  logic [15:0]         mf_dout,
    input  logic [15:0]         ma_dout,
    input  logic [15:0]         mb_dout,
    input  logic [15:0]         mo_dout,
    input  logic [7:0]          mp_dout,
    input  logic                dma_bsy,
    input  logic                mint,
    output logic                rom_cs,
    output logic                ram_cs,
    output logic [19:1]         main_addr,
    output logic [1:0]          ram_dsn,
    output logic [1:0]          pal_we,
    output logic [1:0]          sh_we,
    output logic [1:0]          nvram_we,
    output logic [1:0]          va_we,
    output logic [1:0]          vb_we,
    output logic [1:0]          fx_we,
    output logic [1:0]          oram_we,
    output logic [14:1]         nvram_addr,

    // cabinet
    input  logic [6:0]          joystick1,
    input  logic [6:0]          joystick2,
    input  logic [6:0]          joystick3,
    input  logic [2:0]          cab_1p,
    input  logic [2:0]          coin,
    input  logic                service,
    input  logic [19:0]         dipsw,

    // video and sound config
    output logic                hflip,
    output logic                vflip,
    output logic                vramcvf,
    output logic [2:0]          prio,
    output logic [SCROLL_W-1:0] scra_x,
    output logic [SCROLL_W-1:0] scra_y,
    output logic [SCROLL_W-1:0] scrb_x,
    output logic [SCROLL_W-1:0] scrb_y,
    output logic [15:0]         obj_dx,
    output logic [15:0]         obj_dy,
    output logic                dma_on,
    output logic                sint,
    output logic                sndon,
    output logic [7:0]          snd_latch
);

    twin16_cpu_if cpu ();

    region_t region;
    logic    mint_en;

    assign cpu.addr  = addr;
    assign cpu.wdata = cpu_dout;
    assign cpu.as_n  = as_n;
    assign cpu.uds_n = uds_n;
    assign cpu.lds_n = lds_n;
    assign cpu.rnw   = rnw;

    twin16_bus_map u_bus_map (
        .clk        (clk),
        .rst        (rst),
        .bus        (cpu.decode),
        .rom_data   (rom_data),
        .ram_dout   (ram_dout),
        .sh_dout    (sh_dout),
        .nvram_dout (nvram_dout),
        .mf_dout    (mf_dout),
        .ma_dout    (ma_dout),
        .mb_dout    (mb_dout),
        .mo_dout    (mo_dout),
        .mp_dout    (mp_dout),
        .dma_bsy    (dma_bsy),
        .joystick1  (joystick1),
        .joystick2  (joystick2),
        .joystick3  (joystick3),
        .cab_1p     (cab_1p),
        .coin       (coin),
        .service    (service),
        .dipsw      (dipsw),
        .region     (region),
        .rom_cs     (rom_cs),
        .ram_cs     (ram_cs),
        .main_addr  (main_addr),
        .ram_dsn    (ram_dsn),
        .pal_we     (pal_we),
        .sh_we      (sh_we),
        .nvram_we   (nvram_we),
        .va_we      (va_we),
        .vb_we      (vb_we),
        .fx_we      (fx_we),
        .oram_we    (oram_we),
        .nvram_addr (nvram_addr),
        .cpu_din    (cpu_din)
    );

    twin16_sys_regs u_sys_regs (
        .clk        (clk),
        .rst        (rst),
        .bus        (cpu.regs),
        .region     (region),
        .hflip      (hflip),
        .vflip      (vflip),
        .vramcvf    (vramcvf),
        .prio       (prio),
        .scra_x     (scra_x),
        .scra_y     (scra_y),
        .scrb_x     (scrb_x),
        .scrb_y     (scrb_y),
        .obj_dx     (obj_dx),
        .obj_dy     (obj_dy),
        .dma_on     (dma_on),
        .mint_en    (mint_en),
        .sint       (sint),
        .sndon      (sndon),
        .snd_latch  (snd_latch)
    );

    twin16_dtack_gen #(
        .CEN_NUM    (CEN_NUM),
        .CEN_DEN    (CEN_DEN)
    ) u_dtack_gen (
        .clk        (clk),
        .rst        (rst),
        .bus        (cpu.timing),
        .region     (region),
        .rom_ok     (rom_ok),
        .ram_ok     (ram_ok),
        .dma_bsy    (dma_bsy),
        .cpu_cen    (cpu_cen),
        .cpu_cenb   (cpu_cenb),
        .dtack_n    (dtack_n)
    );

    twin16_ints u_ints (
        .clk        (clk),
        .rst        (rst),
        .lvbl       (lvbl),
        .mint       (mint),
        .mint_en    (mint_en),
        .bus        (cpu.irq),
        .ipl_n      (ipl_n),
        .vpa_n      (vpa_n)
    );

endmodule

//--- tb/twin16_main_tb.sv
// testbench for the main cpu glue: bus master tasks, memory models, assertions
`timescale 1ns/1ps

module twin16_main_tb import twin16_main_pkg::*; ();

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic lvbl = 1'b1;
    logic [23:1] addr = '0;
    logic [15:0] cpu_dout = '0;
    logic as_n = 1'b1, uds_n = 1'b1, lds_n = 1'b1, rnw = 1'b1;
    logic [15:0] cpu_din;
    logic dtack_n, vpa_n, cpu_cen, cpu_cenb;
    logic [2:0] ipl_n;
    logic [15:0] rom_data, ram_dout, sh_dout, nvram_dout, mf_dout, ma_dout, mb_dout, mo_dout;
    logic [7:0] mp_dout;
    logic rom_ok = 1'b0, ram_ok = 1'b0, dma_bsy = 1'b0, mint = 1'b1;
    logic rom_cs, ram_cs;
    logic [19:1] main_addr;
    logic [1:0] ram_dsn, pal_we, sh_we, nvram_we, va_we, vb_we, fx_we, oram_we;
    logic [14:1] nvram_addr;
    logic [6:0] joystick1 = 7'h15, joystick2 = 7'h2a, joystick3 = 7'h4c;
    logic [2:0] cab_1p = 3'h5, coin = 3'h2;
    logic service = 1'b0;
    logic [19:0] dipsw = 20'h9c3a5;
    logic hflip, vflip, vramcvf, sint, sndon, dma_on;
    logic [2:0] prio;
    logic [SCROLL_W-1:0] scra_x, scra_y, scrb_x, scrb_y;
    logic [15:0] obj_dx, obj_dy;
    logic [7:0] snd_latch;

    int errors = 0;
    logic [13:0] strobes;       // pal, sh, nv, va, vb, fx, oram
    logic [3:0] seen_sel;       // rom_cs, ram_cs, ram_dsn
    logic [14:1] seen_nv_addr;
    logic [31:0] rnd_rom = 32'd86;
    logic [31:0] rnd_ram = 32'd86;
    logic [2:0] rom_wait = '0, ram_wait = '0;
    logic tb_busy;

    twin16_main i_dut (.*);

    always #4 clk = ~clk;

    // memory models, values derived from the address
    assign rom_data   = {4'ha, main_addr[12:1]};
    assign ram_dout   = main_addr[16:1] ^ 16'h5a5a;
    assign sh_dout    = ~main_addr[16:1];
    assign nvram_dout = {2'b00, nvram_addr};
    assign mf_dout    = main_addr[16:1] + 16'd1;
    assign ma_dout    = {4'h1, main_addr[12:1]};
    assign mb_dout    = {4'h2, main_addr[12:1]};
    assign mo_dout    = {4'h3, main_addr[12:1]};
    assign mp_dout    = main_addr[8:1];

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ok goes high a random number of clocks into each access
    always @(posedge clk) begin
        #2;
        if (!rom_cs) begin
            rom_ok = 1'b0;
            rom_wait = rnd_rom[2:0];
            rnd_rom = xorshift(rnd_rom);
        end else if (rom_wait == 3'd0) rom_ok = 1'b1;
        else rom_wait = rom_wait - 3'd1;
        if (!ram_cs) begin
            ram_ok = 1'b0;
            ram_wait = rnd_ram[2:0];
            rnd_ram = xorshift(rnd_ram);
        end else if (ram_wait == 3'd0) ram_ok = 1'b1;
        else ram_wait = ram_wait - 3'd1;
    end

    // slow memory or object ram under dma, decoded from the bus pins
    assign tb_busy = !as_n && ((addr[20:18] == 3'b000 && !rom_ok) ||
                               (addr[20:17] == 4'b0011 && !(uds_n && lds_n) && !ram_ok) ||
                               (addr[20] && addr[18:17] == 2'b10 && dma_bsy));

    a_no_busy_ack: assert property (@(posedge clk) disable iff (rst)
        $fell(dtack_n) |-> $past(!tb_busy)) else begin
        errors++;
        $display("dtack fell while the selected memory was busy");
    end
    a_min_wait: assert property (@(posedge clk) disable iff (rst)
        $fell(dtack_n) |-> $past(!as_n, 1) && $past(!as_n, 2) && $past(!as_n, 3)) else begin
        errors++;
        $display("dtack fell less than two clocks after as_n");
    end
    a_release: assert property (@(posedge clk) disable iff (rst)
        $rose(as_n) |=> dtack_n) else begin
        errors++;
        $display("dtack stayed low after as_n rose");
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic bus_cycle(input logic [23:0] a, input logic wr, input logic [15:0] d,
                             input logic [1:0] dsn, output logic [15:0] rd);
        int n;
        @(posedge clk);
        #1;
        addr = a[23:1];
        rnw = !wr;
        cpu_dout = d;
        as_n = 1'b0;
        {uds_n, lds_n} = dsn;
        n = 0;
        while (dtack_n !== 1'b0 && n < 200) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (dtack_n !== 1'b0) begin
            errors++;
            $display("timeout waiting for dtack at address %h", a);
        end
        rd = cpu_din;
        strobes = {pal_we, sh_we, nvram_we, va_we, vb_we, fx_we, oram_we};
        seen_sel = {rom_cs, ram_cs, ram_dsn};
        seen_nv_addr = nvram_addr;
        as_n = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        rnw = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (dtack_n !== 1'b1 && n < 4);
    endtask

    // write and compare the strobe set, pos counts from oram upward
    task automatic write_strobe(input logic [23:0] a, input logic [1:0] dsn, input int pos);
        logic [15:0] rd;
        logic [1:0]  lanes;
        logic [13:0] exp;
        bus_cycle(a, 1'b1, 16'h1234, dsn, rd);
        lanes = ~dsn;
        exp = pos < 0 ? 14'd0 : ({12'd0, lanes} << (2 * pos));
        check_value("write strobes", 32'(strobes), 32'(exp));
    endtask

    task automatic read_expect(input logic [23:0] a, input logic [15:0] exp, input string name);
        logic [15:0] rd;
        bus_cycle(a, 1'b0, 16'h0000, 2'b00, rd);
        check_value(name, 32'(rd), 32'(exp));
    endtask

    task automatic wait_ipl(input logic [2:0] exp);
        int n;
        n = 0;
        while (ipl_n !== exp && n < 20) begin
            @(posedge clk);
            #1;
            n++;
        end
        check_value("ipl_n", 32'(ipl_n), 32'(exp));
    endtask

    task automatic acknowledge(input logic [2:0] level);
        int n;
        @(posedge clk);
        #1;
        addr = {20'hfffff, level};
        as_n = 1'b0;
        lds_n = 1'b0;
        n = 0;
        while (vpa_n !== 1'b0 && n < 10) begin
            @(posedge clk);
            #1;
            n++;
        end
        check_value("vpa_n", 32'(vpa_n), 32'd0);
        as_n = 1'b1;
        lds_n = 1'b1;
        repeat (2) @(posedge clk);
        #1;
    endtask

    initial begin
        logic [15:0] rd;
        int cens;
        int cenbs;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        // reset values before any write
        check_value("dtack_n", 32'(dtack_n), 32'd1);
        check_value("vpa_n", 32'(vpa_n), 32'd1);
        check_value("ipl_n", 32'(ipl_n), 32'h7);
        check_value("sint", 32'(sint), 32'd1);
        check_value("control", 32'({sndon, dma_on, hflip, vflip, prio}), 32'd0);
        check_value("scroll a", 32'({scra_x, scra_y}), 32'd0);
        check_value("scroll b", 32'({scrb_x, scrb_y}), 32'd0);
        check_value("obj offsets", {obj_dx, obj_dy}, 32'd0);

        write_strobe(24'h080010, 2'b10, 6);   // palette low byte
        write_strobe(24'h040020, 2'b00, 5);
        write_strobe(24'h0b0002, 2'b01, 4);
        write_strobe(24'h100100, 2'b00, 1);
        write_strobe(24'h120040, 2'b00, 3);   // a13 low, scroll a
        write_strobe(24'h122040, 2'b10, 2);
        write_strobe(24'h140008, 2'b00, 0);
        write_strobe(24'h060000, 2'b01, -1);  // work ram has no strobe here
        check_value("ram select", 32'(seen_sel), 32'h5);
        // nvram page select
        bus_cycle(24'h0b0400, 1'b1, 16'h1500, 2'b00, rd);
        check_value("nvram_we", 32'(strobes[9:8]), 32'd0);
        read_expect(24'h0b0002, 16'h2a01, "nvram_dout");
        check_value("nvram_addr", 32'(seen_nv_addr), 32'h2a01);

        read_expect(24'h000246, 16'ha123, "rom_data");
        check_value("rom select", 32'(seen_sel), 32'h8);
        read_expect(24'h06000a, 16'h5a5f, "ram_dout");
        read_expect(24'h040010, 16'hfff7, "sh_dout");
        read_expect(24'h08000c, 16'h0006, "mp_dout");
        read_expect(24'h100008, 16'h0005, "mf_dout");
        read_expect(24'h120004, 16'h1002, "ma_dout");
        read_expect(24'h122004, 16'h2002, "mb_dout");
        read_expect(24'h0a0000, {8'h00, 1'b1, service, cab_1p, coin}, "cabinet");
        read_expect(24'h0a0002, {9'h001, joystick1}, "joystick1");
        read_expect(24'h0a0004, {9'h001, joystick2}, "joystick2");
        read_expect(24'h0a0006, {9'h001, joystick3}, "joystick3");
        read_expect(24'h0a0010, {8'h00, dipsw[15:8]}, "dipsw high");
        read_expect(24'h0a0012, {8'h00, dipsw[7:0]}, "dipsw low");
        read_expect(24'h0a0018, {12'h00f, dipsw[19:16]}, "dipsw top");
        dma_bsy = 1'b1;
        read_expect(24'h0c0000, 16'h0001, "dma_bsy");
        fork
            read_expect(24'h14000c, 16'h3006, "mo_dout");
            begin
                repeat (12) @(posedge clk);
                #1;
                dma_bsy = 1'b0;
            end
        join
        read_expect(24'h0c0000, 16'h0000, "dma_bsy");

        // sysflag and io registers
        bus_cycle(24'h0c0000, 1'b1, 16'h002d, 2'b00, rd);
        bus_cycle(24'h0c0002, 1'b1, 16'hbeef, 2'b00, rd);
        bus_cycle(24'h0c0004, 1'b1, 16'h1357, 2'b00, rd);
        bus_cycle(24'h0c0006, 1'b1, 16'h0123, 2'b00, rd);
        bus_cycle(24'h0c0008, 1'b1, 16'h00fe, 2'b00, rd);
        bus_cycle(24'h0c000a, 1'b1, 16'h01a5, 2'b00, rd);
        bus_cycle(24'h0c000c, 1'b1, 16'h005a, 2'b00, rd);
        bus_cycle(24'h0a0008, 1'b1, 16'h00c3, 2'b00, rd);
        bus_cycle(24'h0a0000, 1'b1, 16'h0048, 2'b00, rd);   // dma_on and sndon
        check_value("write strobes", 32'(strobes), 32'd0);
        check_value("control", 32'({vramcvf, prio, hflip, vflip}), 32'h2d);
        check_value("obj_dx", 32'(obj_dx), 32'hbeef);
        check_value("obj_dy", 32'(obj_dy), 32'h1357);
        check_value("scra_x", 32'(scra_x), 32'h123);
        check_value("scra_y", 32'(scra_y), 32'h0fe);
        check_value("scrb_x", 32'(scrb_x), 32'h1a5);
        check_value("scrb_y", 32'(scrb_y), 32'h05a);
        check_value("snd_latch", 32'(snd_latch), 32'hc3);
        check_value("io control", 32'({dma_on, sint, sndon}), 32'h5);

        // interrupts
        lvbl = 1'b0;
        wait_ipl(~IRQ_VBL_LEVEL);
        bus_cycle(24'h0a0000, 1'b1, 16'h0030, 2'b00, rd);   // mint_en with sint high
        mint = 1'b0;
        wait_ipl(~IRQ_SUB_LEVEL);
        mint = 1'b1;
        acknowledge(IRQ_SUB_LEVEL);
        wait_ipl(~IRQ_VBL_LEVEL);
        acknowledge(IRQ_VBL_LEVEL);
        wait_ipl(3'b111);
        bus_cycle(24'h0a0000, 1'b1, 16'h0010, 2'b00, rd);
        mint = 1'b0;
        repeat (6) @(posedge clk);
        #1;
        check_value("ipl_n", 32'(ipl_n), 32'h7);   // masked sub request
        mint = 1'b1;
        lvbl = 1'b1;

        // clock enable ratio, 160 clocks is ten whole periods
        cens = 0;
        cenbs = 0;
        repeat (160) begin
            @(posedge clk);
            #1;
            if (cpu_cen) cens++;
            if (cpu_cenb) cenbs++;
        end
        check_value("cpu_cen count", 32'(cens), 32'd30);
        check_value("cpu_cenb count", 32'(cenbs), 32'd30);

        $display("checks done, errors %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- twin16_main.f
hw/twin16_main_pkg.sv
hw/twin16_cpu_if.sv
hw/twin16_bus_map.sv
hw/twin16_sys_regs.sv
hw/twin16_dtack_gen.sv
hw/twin16_ints.sv
hw/twin16_main.sv
tb/twin16_main_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the main cpu glue testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f twin16_main.f \
    --top-module twin16_main_tb \
    -Mdir obj_dir \
    -o sim_twin16_main

out="$(./obj_dir/sim_twin16_main)"
echo "$out"

if grep -qx "RESULT: PASS" <<< "$out"; then
    exit 0
else
    exit 1
fi
